//--- build.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/sample_tagger.sv
rtl/cyclic_fifo.sv
rtl/frame_serializer.sv
rtl/capture_top.sv
dv/capture_tb.sv

//--- dv/capture_tb.sv
//////////////////////////////
// capture path testbench
// drives strobes, decodes the serial line
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module capture_tb;

	localparam int DW = `DAT_WIDTH;
	localparam int SW = `SEQ_WIDTH;
	localparam int WORD_W = `SEQ_WIDTH + `DAT_WIDTH;
	localparam int DEPTH = 1 << `ADR_WIDTH;
	localparam int FRAME_CYCLES = `FRAME_BITS * `BIT_CYCLES;
	localparam int TOTAL_SAMPLES = 20 + 1 + 30 + 40; // overflow, gap, order, burst

	logic clk = 1'b0;
	logic reset;
	logic sample_strobe;
	logic [DW-1:0] sample_data;
	logic line_ready;
	wire serial_out;
	wire frame_busy;
	wire [7:0] drop_count;

	// reference model of the path
	logic [WORD_W-1:0] exp_q [$]; // words still to come out of the line
	int occ; // modelled fifo occupancy
	int remain; // cycles left in the current frame
	logic [SW-1:0] seq_model;
	logic [7:0] exp_drops;
	logic model_busy;

	string test_name;
	int errors = 0;
	int frames_decoded = 0;
	logic [SW-1:0] prev_seq = '0;
	bit check_step = 1'b0; // expect unbroken seq steps

	capture_top i_dut (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample_data   (sample_data),
		.line_ready    (line_ready),
		.serial_out    (serial_out),
		.frame_busy    (frame_busy),
		.drop_count    (drop_count)
	);

	always #4 clk = ~clk;

	task automatic value_fail(input string what, input int unsigned expected,
		input int unsigned actual);
		errors++;
		$display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR in %s: %s", test_name, msg);
	endtask

	// count consecutive strobe cycles, fresh data each
	task automatic send_burst(input int count);
		for (int n = 0; n < count; n++)
		begin
			@(posedge clk);
			sample_strobe <= 1'b1;
			sample_data <= DW'($urandom);
		end
		@(posedge clk);
		sample_strobe <= 1'b0;
	endtask

	task automatic wait_drain();
		@(negedge clk);
		while ((exp_q.size() != 0) || frame_busy)
		begin
			@(negedge clk);
		end
	endtask

	// fifo flags are registered, so a strobe sees the occupancy before this edge
	assign model_busy = (remain != 0);

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			occ <= 0;
			remain <= 0;
			seq_model <= '0;
			exp_drops <= '0;
		end
		else
		begin : model_step
			bit pop;
			bit push;
			pop = (remain <= 1) && (occ != 0) && line_ready; // idle or last stop cycle
			push = sample_strobe && (occ != DEPTH);
			if (sample_strobe)
			begin
				seq_model <= seq_model + 1'b1;
				if (!push && (exp_drops != 8'hff))
				begin
					exp_drops <= exp_drops + 8'd1;
				end
			end
			if (push)
			begin
				exp_q.push_back({seq_model, sample_data});
			end
			occ <= occ + int'(push) - int'(pop);
			if (pop)
			begin
				remain <= FRAME_CYCLES;
			end
			else if (remain != 0)
			begin
				remain <= remain - 1;
			end
		end
	end

	a_busy_window: assert property (
		@(posedge clk) disable iff (reset)
		frame_busy == model_busy
	) else value_fail("frame_busy", $sampled(model_busy), $sampled(frame_busy));

	a_drop_count: assert property (
		@(posedge clk) disable iff (reset)
		drop_count == exp_drops
	) else value_fail("drop_count", $sampled(exp_drops), $sampled(drop_count));

	a_idle_high: assert property (
		@(posedge clk) disable iff (reset)
		!frame_busy |-> serial_out
	) else report_error("serial line low outside a frame");

	// line decoder, one frame per falling edge of the idle line
	initial
	begin : decoder
		logic [`FRAME_BITS-1:0] bits;
		logic [WORD_W-1:0] payload;
		logic [WORD_W-1:0] expected;
		logic level;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge serial_out);
			for (int i = 0; i < `FRAME_BITS; i++)
			begin
				for (int c = 0; c < `BIT_CYCLES; c++)
				begin
					@(negedge clk);
					if (c == 0)
					begin
						level = serial_out;
					end
					assert (serial_out === level)
						else report_error($sformatf("bit %0d changed within its period", i));
					assert (frame_busy === 1'b1)
						else report_error($sformatf("frame_busy low during bit %0d", i));
				end
				bits[i] = level;
			end
			payload = bits[WORD_W:1];
			assert (bits[0] == 1'b0) else value_fail("start bit", 0, bits[0]);
			assert (bits[`FRAME_BITS-1] == 1'b1)
				else value_fail("stop bit", 1, bits[`FRAME_BITS-1]);
			assert ((^bits[WORD_W+1:1]) == 1'b0)
				else value_fail("parity bit", ^payload, bits[WORD_W+1]);
			if (exp_q.size() == 0)
			begin
				report_error("frame arrived with no sample pending");
			end
			else
			begin
				expected = exp_q.pop_front();
				assert (payload == expected) else value_fail("word", expected, payload);
			end
			if (check_step)
			begin
				assert (payload[WORD_W-1:DW] == SW'(prev_seq + 1'b1))
					else value_fail("seq step", SW'(prev_seq + 1'b1), payload[WORD_W-1:DW]);
			end
			prev_seq = payload[WORD_W-1:DW];
			frames_decoded++;
		end
	end

	initial
	begin : watchdog
		#((TOTAL_SAMPLES + 20) * FRAME_CYCLES * 8);
		$display("timeout: the line did not drain within the allowed run time");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin : stimulus
		int unsigned seed_val;
		int f0;
		logic [SW-1:0] seq_before;
		seed_val = $urandom(88);
		reset = 1'b1;
		sample_strobe = 1'b0;
		sample_data = '0;
		line_ready = 1'b0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// quiet line after reset
		repeat (10)
		begin
			@(negedge clk);
			assert (serial_out === 1'b1) else value_fail("serial_out", 1, serial_out);
			assert (frame_busy === 1'b0) else value_fail("frame_busy", 0, frame_busy);
			assert (drop_count === 8'd0) else value_fail("drop_count", 0, drop_count);
		end

		test_name = "overflow";
		repeat (20) send_burst(1);
		@(negedge clk);
		assert (drop_count == 8'd4) else value_fail("drop_count", 4, drop_count);

		test_name = "drain";
		f0 = frames_decoded;
		@(posedge clk);
		line_ready <= 1'b1;
		wait_drain();
		assert (frames_decoded - f0 == DEPTH)
			else value_fail("frame count", DEPTH, frames_decoded - f0);
		seq_before = prev_seq;
		send_burst(1);
		wait_drain();
		assert (SW'(prev_seq - seq_before) == SW'(5)) // one step plus 4 dropped
			else value_fail("seq gap", 5, SW'(prev_seq - seq_before));

		test_name = "order";
		check_step = 1'b1;
		repeat (30)
		begin
			repeat ($urandom_range(50, 20)) @(posedge clk);
			send_burst(1);
		end
		wait_drain();
		check_step = 1'b0;

		test_name = "burst";
		send_burst(40);
		wait_drain();
		assert (drop_count == exp_drops) else value_fail("drop_count", exp_drops, drop_count);
		assert (exp_q.size() == 0) else report_error("words left undelivered after burst");

		repeat (4) @(posedge clk);
		$display("errors: %0d  frames: %0d  drops: %0d", errors, frames_decoded, drop_count);
		if (errors == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/capture_top.sv
//////////////////////////////
// capture top
// tagger into fifo into serial framer
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module capture_top (
	input wire clk,
	input wire reset,
	input wire sample_strobe,
	input wire [`DAT_WIDTH-1:0] sample_data,
	input wire line_ready,
	output logic serial_out,
	output logic frame_busy,
	output logic [7:0] drop_count
);
	import stream_pkg::*;

	sample_word_t wr_word; // tagged word into the fifo
	sample_word_t rd_word; // head of the fifo
	logic wr;
	logic rd;
	logic empty;
	logic full;

	sample_tagger i_tagger (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample_data   (sample_data),
		.full          (full),
		.wr            (wr),
		.wr_word       (wr_word),
		.drop_count    (drop_count)
	);

	cyclic_fifo #(
		.payload_t (sample_word_t)
	) i_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr      (wr),
		.wr_word (wr_word),
		.rd      (rd),
		.rd_word (rd_word),
		.empty   (empty),
		.full    (full)
	);

	frame_serializer i_serializer (
		.clk        (clk),
		.reset      (reset),
		.rd_word    (rd_word),
		.empty      (empty),
		.line_ready (line_ready),
		.rd         (rd),
		.serial_out (serial_out),
		.frame_busy (frame_busy)
	);

endmodule

`default_nettype wire

//--- rtl/cyclic_fifo.sv
//////////////////////////////
// cyclic fifo
// register ring, first word fall-through
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module cyclic_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input wire clk,
	input wire reset,
	input wire wr,
	input wire payload_t wr_word,
	input wire rd,
	output payload_t rd_word,
	output logic empty,
	output logic full
);
	localparam int DEPTH = 1 << `ADR_WIDTH;

	payload_t mem [DEPTH];

	logic [`ADR_WIDTH-1:0] w_ptr; // next slot to fill
	logic [`ADR_WIDTH-1:0] r_ptr; // oldest word
	logic [`ADR_WIDTH-1:0] w_ptr_succ;
	logic [`ADR_WIDTH-1:0] r_ptr_succ;

	// pointers wrap on their own at DEPTH
	assign w_ptr_succ = w_ptr + 1'b1;
	assign r_ptr_succ = r_ptr + 1'b1;

	// head of the queue is always on the output
	assign rd_word = mem[r_ptr];

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			mem[w_ptr] <= wr_word;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			w_ptr <= '0;
			r_ptr <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			case ({wr, rd})
				2'b10: // write only
				begin
					w_ptr <= w_ptr_succ;
					empty <= 1'b0;
					full <= (w_ptr_succ == r_ptr);
				end
				2'b01: // read only
				begin
					r_ptr <= r_ptr_succ;
					full <= 1'b0;
					empty <= (r_ptr_succ == w_ptr);
				end
				2'b11: // both move, occupancy unchanged
				begin
					w_ptr <= w_ptr_succ;
					r_ptr <= r_ptr_succ;
				end
				default:
				begin
					w_ptr <= w_ptr;
				end
			endcase
		end
	end

	// writer must hold off while full
	a_wr_not_full: assert property (
		@(posedge clk) disable iff (reset)
		wr |-> !full
	) else $error("write into full fifo");

	// reader must hold off while empty
	a_rd_not_empty: assert property (
		@(posedge clk) disable iff (reset)
		rd |-> !empty
	) else $error("read from empty fifo");

	a_flags_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(full && empty)
	) else $error("fifo full and empty at once");

endmodule

`default_nettype wire

//--- rtl/frame_serializer.sv
//////////////////////////////
// frame serializer
// start, payload lsb first, even parity, stop
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module frame_serializer (
	input wire clk,
	input wire reset,
	input wire stream_pkg::sample_word_t rd_word,
	input wire empty,
	input wire line_ready,
	output logic rd,
	output logic serial_out,
	output logic frame_busy
);
	import stream_pkg::*;

	localparam int CYC_W = (`BIT_CYCLES > 1) ? $clog2(`BIT_CYCLES) : 1;
	localparam int IDX_W = $clog2(`FRAME_BITS);

	typedef enum logic {IDLE, SHIFT} state_t;

	state_t state;
	frame_t shreg; // bit 0 drives the line, ones shift in behind
	logic [CYC_W-1:0] cyc_cnt; // cycles spent in the current bit
	logic [IDX_W-1:0] bit_idx; // bit of the frame on the line
	logic bit_end;
	logic frame_end;

	assign bit_end = (cyc_cnt == CYC_W'(`BIT_CYCLES - 1));
	assign frame_end = (state == SHIFT) && bit_end
		&& (bit_idx == IDX_W'(`FRAME_BITS - 1));

	// pop in idle or on the last cycle of a stop bit, so frames can run back to back
	assign rd = ((state == IDLE) || frame_end) && !empty && line_ready;

	assign serial_out = shreg[0];
	assign frame_busy = (state == SHIFT);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			shreg <= '1; // line idles high
			cyc_cnt <= '0;
			bit_idx <= '0;
		end
		else if (rd)
		begin
			state <= SHIFT;
			shreg <= {1'b1, ^rd_word, rd_word, 1'b0};
			cyc_cnt <= '0;
			bit_idx <= '0;
		end
		else if (state == SHIFT)
		begin
			if (bit_end)
			begin
				cyc_cnt <= '0;
				shreg <= {1'b1, shreg[`FRAME_BITS-1:1]};
				if (frame_end)
				begin
					state <= IDLE;
					bit_idx <= '0;
				end
				else
				begin
					bit_idx <= bit_idx + 1'b1;
				end
			end
			else
			begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

	// a pop only takes a real word, and its start bit follows next cycle
	a_rd_starts_frame: assert property (
		@(posedge clk) disable iff (reset)
		rd |-> !empty ##1 (frame_busy && !serial_out)
	) else $error("pop did not start a frame");

	a_idle_line_high: assert property (
		@(posedge clk) disable iff (reset)
		!frame_busy |-> serial_out
	) else $error("line low outside a frame");

endmodule

`default_nettype wire

//--- rtl/sample_tagger.sv
//////////////////////////////
// sample tagger
// tags strobes with a sequence number, counts drops
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module sample_tagger (
	input wire clk,
	input wire reset,
	input wire sample_strobe,
	input wire [`DAT_WIDTH-1:0] sample_data,
	input wire full,
	output logic wr,
	output stream_pkg::sample_word_t wr_word,
	output logic [7:0] drop_count
);
	import stream_pkg::*;

	seq_t seq_cnt; // tag for the next strobe

	// written in the strobe's own cycle
	assign wr = sample_strobe && !full;
	assign wr_word = '{seq: seq_cnt, data: sample_data};

	// the tag advances on every strobe, even a dropped one,
	// so the far end sees a hole in the sequence
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			seq_cnt <= '0;
		end
		else if (sample_strobe)
		begin
			seq_cnt <= seq_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			drop_count <= '0;
		end
		else if (sample_strobe && full && (drop_count != 8'hff))
		begin
			drop_count <= drop_count + 8'd1; // sticks at 255
		end
	end

	// the drop count only climbs and never wraps back to zero
	a_drop_monotonic: assert property (
		@(posedge clk) disable iff (reset)
		1'b1 |=> (drop_count >= $past(drop_count))
	) else $error("drop count went backwards");

endmodule

`default_nettype wire

//--- rtl/stream_consts.svh
//////////////////////////////
// capture path sizes
// fifo depth, word widths, serial bit timing
//////////////////////////////
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

`define ADR_WIDTH 4 // 16 words deep
`define DAT_WIDTH 8
`define SEQ_WIDTH 4

// serial line
`define BIT_CYCLES 2
`define FRAME_BITS 15 // start + 12 payload + parity + stop

`endif

//--- rtl/stream_pkg.sv
//////////////////////////////
// capture path types
// tagged sample word and serial frame
//////////////////////////////
`default_nettype none

`include "stream_consts.svh"

package stream_pkg;

	typedef logic [`SEQ_WIDTH-1:0] seq_t;
	typedef logic [`DAT_WIDTH-1:0] data_t;

	// one serial frame, bit 0 goes out first
	typedef logic [`FRAME_BITS-1:0] frame_t;

	// data sits in the low bits so it leaves the line first
	typedef struct packed
	{
		seq_t seq;
		data_t data;
	} sample_word_t;

endpackage

`default_nettype wire
